//--- sobelPkg.sv
/*
 * shared definitions of the sobel edge viewer
 * gray and rgb565 sample types, view mode and pixel class enums,
 * threshold table and the gray to rgb565 packing rule
 */

package sobelPkg;

	typedef logic [7:0]  grayT; // one gray sample
	typedef logic [15:0] rgbT;  // one rgb565 pixel

	// display mode, held for a whole frame
	typedef enum logic [1:0] {
		viewGray,      // image as stored
		viewEdge,      // sobel magnitude
		viewThreshold  // magnitude with small values cleared
	} viewModeT;

	// where a screen position falls relative to the image
	typedef enum logic [1:0] {
		pixelOutside,  // off the image, black
		pixelBorder,   // first/last row or column
		pixelInterior  // full 3x3 window available
	} pixelClassT;

	// ------------------------------------------------------------------------
	// threshold selection
	localparam int thresholdCount = 7; // one-hot select bits

	// entry 0 is the default, entry i+1 belongs to select bit i
	localparam grayT thresholdTable [0:thresholdCount] = '{
		8'd50, 8'd100, 8'd120, 8'd140, 8'd160, 8'd180, 8'd200, 8'd220
	};

	// ------------------------------------------------------------------------
	// gray to rgb565, top bits of the sample into each channel
	function automatic rgbT toRgb565(input grayT gray);
		return {gray[7:3], gray[7:2], gray[7:3]}; // r5 g6 b5
	endfunction

endpackage

//--- frameScanner.sv
/*
 * raster scan of the screen
 * one request per position, x fastest, view mode frozen per frame
 */

`timescale 1ns/1ps

module frameScanner import sobelPkg::*; #(
	parameter int screenWidth  = 20,
	parameter int screenHeight = 14,
	localparam int xWidth = $clog2(screenWidth),
	localparam int yWidth = $clog2(screenHeight)
) (
	input  logic              clock,
	input  logic              resetApp,
	input  viewModeT          viewMode,
	input  logic              reqReady,
	output logic              reqValid,
	output logic [xWidth-1:0] reqX,
	output logic [yWidth-1:0] reqY,
	output viewModeT          reqMode
);

	logic lastX; // end of the current line
	logic lastY; // last line of the screen
	logic step;  // request taken by fetch

	assign lastX = (reqX == xWidth'(screenWidth - 1));
	assign lastY = (reqY == yWidth'(screenHeight - 1));
	assign step  = reqValid && reqReady;

	always_ff @(posedge clock or posedge resetApp) begin
		if (resetApp) begin
			reqValid <= 1'b0;
			reqX     <= '0;
			reqY     <= '0;
			reqMode  <= viewGray;
		end else if (!reqValid) begin
			reqValid <= 1'b1;     // first request after reset is (0,0)
			reqMode  <= viewMode; // so the mode is taken here too
		end else if (step) begin
			if (lastX) begin
				reqX <= '0;
				if (lastY) begin
					reqY    <= '0;
					reqMode <= viewMode; // new frame starts, sample the mode
				end else begin
					reqY <= reqY + 1'b1;
				end
			end else begin
				reqX <= reqX + 1'b1;
			end
		end
	end

endmodule

//--- imageMemory.sv
/*
 * image store, row-major, one sample per address
 * write through the load port, registered read
 */

`timescale 1ns/1ps

module imageMemory import sobelPkg::*; #(
	parameter int imageWidth  = 16,
	parameter int imageHeight = 12,
	localparam int depth     = imageWidth * imageHeight,
	localparam int addrWidth = $clog2(depth)
) (
	input  logic                 clock,
	input  logic                 loadValid,
	input  logic [addrWidth-1:0] loadAddr,
	input  grayT                 loadData,
	input  logic                 memRead,
	input  logic [addrWidth-1:0] memAddr,
	output grayT                 memData
);

	grayT store [0:depth-1]; // y * imageWidth + x

	// load happens before any frame, never together with reads
	always_ff @(posedge clock) begin
		if (loadValid) begin
			store[loadAddr] <= loadData;
		end
	end

	// data one clock after memRead, held otherwise
	always_ff @(posedge clock) begin
		if (memRead) begin
			memData <= store[memAddr];
		end
	end

endmodule

//--- windowFetch.sv
/*
 * request classification and window read
 * outside / border: straight to output
 * gray view: centre read, edge views: eight neighbour reads
 */

`timescale 1ns/1ps

module windowFetch import sobelPkg::*; #(
	parameter int imageWidth   = 16,
	parameter int imageHeight  = 12,
	parameter int screenWidth  = 20,
	parameter int screenHeight = 14,
	localparam int addrWidth = $clog2(imageWidth * imageHeight),
	localparam int xWidth    = $clog2(screenWidth),
	localparam int yWidth    = $clog2(screenHeight)
) (
	input  logic                 clock,
	input  logic                 resetApp,
	input  logic                 reqValid,
	input  logic [xWidth-1:0]    reqX,
	input  logic [yWidth-1:0]    reqY,
	input  viewModeT             reqMode,
	output logic                 reqReady,
	output logic                 memRead,
	output logic [addrWidth-1:0] memAddr,
	input  grayT                 memData,
	output logic                 winValid,
	input  logic                 winReady,
	output grayT                 winP1, winP2, winP3, winP4,
	output grayT                 winP6, winP7, winP8, winP9,
	output grayT                 winCentre,
	output pixelClassT           winClass,
	output viewModeT             winMode,
	output logic [xWidth-1:0]    winX,
	output logic [yWidth-1:0]    winY
);

	typedef enum logic [1:0] {stIdle, stFetch, stPresent} fetchStateT;

	// neighbour offsets in read order P1 P2 P3 P4 P6 P7 P8 P9
	localparam int offX [0:7] = '{-1, 0, 1, -1, 1, -1, 0, 1};
	localparam int offY [0:7] = '{-1, -1, -1, 0, 0, 1, 1, 1};

	fetchStateT state;
	logic [3:0] idx;     // read slot, data of slot idx-1 arrives now
	logic [3:0] lastIdx; // 1 for gray, 8 for the window
	logic       accept;
	pixelClassT reqClass;
	grayT       nb [0:7];

	assign reqReady = (state == stIdle) || (state == stPresent && winReady);
	assign accept   = reqValid && reqReady;
	assign winValid = (state == stPresent);
	assign lastIdx  = (winMode == viewGray) ? 4'd1 : 4'd8;
	assign memRead  = (state == stFetch) && (idx < lastIdx);

	// the only bounds test of the design
	always_comb begin
		if (reqX >= imageWidth || reqY >= imageHeight)
			reqClass = pixelOutside;
		else if (reqX == 0 || reqY == 0 || reqX == imageWidth - 1 || reqY == imageHeight - 1)
			reqClass = pixelBorder;
		else
			reqClass = pixelInterior;
	end

	// read address from the latched coordinates
	always_comb begin
		int ax;
		int ay;
		if (winMode == viewGray) begin
			ax = int'(winX);
			ay = int'(winY);
		end else begin
			ax = int'(winX) + offX[idx[2:0]];
			ay = int'(winY) + offY[idx[2:0]];
		end
		memAddr = addrWidth'(ay * imageWidth + ax); // row-major
	end

	// ------------------------------------------------------------------------
	// control
	always_ff @(posedge clock or posedge resetApp) begin
		if (resetApp) begin
			state <= stIdle;
			idx   <= '0;
		end else begin
			case (state)
				stFetch: begin
					idx <= idx + 1'b1;
					if (idx == lastIdx) state <= stPresent; // last sample in
				end
				default: begin
					if (accept) begin
						idx <= '0;
						// nothing to read for black, nor for white in edge views
						if (reqClass == pixelOutside ||
						    (reqClass == pixelBorder && reqMode != viewGray))
							state <= stPresent;
						else
							state <= stFetch;
					end else if (state == stPresent && winReady) begin
						state <= stIdle;
					end
				end
			endcase
		end
	end

	// payload, changes only on accept or while fetching
	always_ff @(posedge clock) begin
		if (accept) begin
			winX     <= reqX;
			winY     <= reqY;
			winMode  <= reqMode;
			winClass <= reqClass;
		end
		if (state == stFetch && idx != 4'd0) begin
			if (winMode == viewGray) winCentre <= memData;
			else nb[3'(idx - 4'd1)] <= memData;
		end
	end

	assign winP1 = nb[0];
	assign winP2 = nb[1];
	assign winP3 = nb[2];
	assign winP4 = nb[3];
	assign winP6 = nb[4];
	assign winP7 = nb[5];
	assign winP8 = nb[6];
	assign winP9 = nb[7];

endmodule

//--- sobelKernel.sv
/*
 * sobel gradient, two registered stages
 * stage one: saturated 1-2-1 sums, stage two: magnitude, threshold, view select
 */

`timescale 1ns/1ps

module sobelKernel import sobelPkg::*; #(
	parameter int screenWidth  = 20,
	parameter int screenHeight = 14,
	localparam int xWidth = $clog2(screenWidth),
	localparam int yWidth = $clog2(screenHeight)
) (
	input  logic              clock,
	input  logic              resetApp,
	input  logic              winValid,
	output logic              winReady,
	input  grayT              winP1, winP2, winP3, winP4,
	input  grayT              winP6, winP7, winP8, winP9,
	input  grayT              winCentre,
	input  pixelClassT        winClass,
	input  viewModeT          winMode,
	input  logic [xWidth-1:0] winX,
	input  logic [yWidth-1:0] winY,
	input  grayT              thresholdValue,
	output logic              grayValid,
	input  logic              grayReady,
	output grayT              grayValue,
	output logic [xWidth-1:0] grayX,
	output logic [yWidth-1:0] grayY
);

	function automatic grayT sat8(input logic [9:0] sum);
		return (sum > 10'd255) ? 8'hFF : sum[7:0];
	endfunction

	logic              s1Valid, s1Ready, s2Ready;
	grayT              s1Top, s1Bottom, s1Left, s1Right, s1Centre;
	pixelClassT        s1Class;
	viewModeT          s1Mode;
	logic [xWidth-1:0] s1X;
	logic [yWidth-1:0] s1Y;
	grayT              gradX, gradY, magnitude, result;
	logic [8:0]        gradSum;

	assign s2Ready  = !grayValid || grayReady;
	assign s1Ready  = !s1Valid || s2Ready;
	assign winReady = s1Ready;

	always_ff @(posedge clock or posedge resetApp) begin
		if (resetApp) begin
			s1Valid   <= 1'b0;
			grayValid <= 1'b0;
		end else begin
			if (s1Ready) s1Valid <= winValid;
			if (s2Ready) grayValid <= s1Valid;
		end
	end

	// ------------------------------------------------------------------------
	// stage one, weighted row and column sums
	always_ff @(posedge clock) begin
		if (winValid && s1Ready) begin
			s1Top    <= sat8(10'(winP1) + {1'b0, winP2, 1'b0} + 10'(winP3));
			s1Bottom <= sat8(10'(winP7) + {1'b0, winP8, 1'b0} + 10'(winP9));
			s1Left   <= sat8(10'(winP1) + {1'b0, winP4, 1'b0} + 10'(winP7));
			s1Right  <= sat8(10'(winP3) + {1'b0, winP6, 1'b0} + 10'(winP9));
			s1Centre <= winCentre;
			s1Class  <= winClass;
			s1Mode   <= winMode;
			s1X      <= winX;
			s1Y      <= winY;
		end
	end

	// stage two, gradients clamped at zero, then summed
	always_comb begin
		gradY     = (s1Top > s1Bottom) ? s1Top - s1Bottom : 8'd0;
		gradX     = (s1Right > s1Left) ? s1Right - s1Left : 8'd0;
		gradSum   = {1'b0, gradY} + {1'b0, gradX};
		magnitude = gradSum[8] ? 8'hFF : gradSum[7:0];
		if (s1Mode == viewThreshold && magnitude < thresholdValue) magnitude = 8'd0;
		case (s1Class)
			pixelOutside: result = 8'd0; // black in every view
			pixelBorder:  result = (s1Mode == viewGray) ? s1Centre : 8'hFF;
			default:      result = (s1Mode == viewGray) ? s1Centre : magnitude;
		endcase
	end

	always_ff @(posedge clock) begin
		if (s1Valid && s2Ready) begin
			grayValue <= result;
			grayX     <= s1X;
			grayY     <= s1Y;
		end
	end

endmodule

//--- pixelFormatter.sv
/*
 * output stage of the pixel stream
 * rgb565 packing and the hold register
 */

`timescale 1ns/1ps

module pixelFormatter import sobelPkg::*; #(
	parameter int screenWidth  = 20,
	parameter int screenHeight = 14,
	localparam int xWidth = $clog2(screenWidth),
	localparam int yWidth = $clog2(screenHeight)
) (
	input  logic              clock,
	input  logic              resetApp,
	input  logic              grayValid,
	output logic              grayReady,
	input  grayT              grayValue,
	input  logic [xWidth-1:0] grayX,
	input  logic [yWidth-1:0] grayY,
	output logic              pixelValid,
	input  logic              pixelReady,
	output logic [xWidth-1:0] pixelX,
	output logic [yWidth-1:0] pixelY,
	output rgbT               pixelData
);

	logic take; // gray transfer this cycle

	assign grayReady = !pixelValid || pixelReady; // empty or draining
	assign take      = grayValid && grayReady;

	always_ff @(posedge clock or posedge resetApp) begin
		if (resetApp) begin
			pixelValid <= 1'b0;
		end else if (take) begin
			pixelValid <= 1'b1;
		end else if (pixelReady) begin
			pixelValid <= 1'b0; // sent, nothing behind it
		end
	end

	// held while the sink stalls
	always_ff @(posedge clock) begin
		if (take) begin
			pixelData <= toRgb565(grayValue);
			pixelX    <= grayX;
			pixelY    <= grayY;
		end
	end

endmodule

//--- sobelEdgeTop.sv
/*
 * top level of the sobel edge viewer
 * scanner -> fetch -> kernel -> formatter, image memory, threshold decode
 */

`timescale 1ns/1ps

module sobelEdgeTop import sobelPkg::*; #(
	parameter int imageWidth   = 16,
	parameter int imageHeight  = 12,
	parameter int screenWidth  = 20,
	parameter int screenHeight = 14,
	localparam int addrWidth = $clog2(imageWidth * imageHeight),
	localparam int xWidth    = $clog2(screenWidth),
	localparam int yWidth    = $clog2(screenHeight)
) (
	input  logic                      clock,
	input  logic                      resetApp,
	input  logic                      loadValid,
	input  logic [addrWidth-1:0]      loadAddr,
	input  grayT                      loadData,
	input  viewModeT                  viewMode,
	input  logic [thresholdCount-1:0] thresholdSelect,
	output logic                      pixelValid,
	input  logic                      pixelReady,
	output logic [xWidth-1:0]         pixelX,
	output logic [yWidth-1:0]         pixelY,
	output rgbT                       pixelData
);

	// ------------------------------------------------------------------------
	// internal streams
	logic reqValid, reqReady, winValid, winReady, grayValid, grayReady, memRead;
	logic [xWidth-1:0]    reqX, winX, grayX;
	logic [yWidth-1:0]    reqY, winY, grayY;
	viewModeT             reqMode, winMode;
	logic [addrWidth-1:0] memAddr;
	grayT                 memData, winCentre, grayValue, thresholdValue;
	grayT                 winP1, winP2, winP3, winP4, winP6, winP7, winP8, winP9;
	pixelClassT           winClass;
	logic [2:0]           thresholdIndex;

	// one-hot select, anything else keeps the default entry
	always_comb begin
		thresholdIndex = 3'd0;
		if ($onehot(thresholdSelect)) begin
			for (int i = 0; i < thresholdCount; i++)
				if (thresholdSelect[i]) thresholdIndex = 3'(i + 1);
		end
	end
	assign thresholdValue = thresholdTable[thresholdIndex];

	frameScanner #(.screenWidth(screenWidth), .screenHeight(screenHeight)) u_frameScanner (
		.clock, .resetApp, .viewMode, .reqReady, .reqValid, .reqX, .reqY, .reqMode
	);

	imageMemory #(.imageWidth(imageWidth), .imageHeight(imageHeight)) u_imageMemory (
		.clock, .loadValid, .loadAddr, .loadData, .memRead, .memAddr, .memData
	);

	windowFetch #(
		.imageWidth(imageWidth), .imageHeight(imageHeight),
		.screenWidth(screenWidth), .screenHeight(screenHeight)
	) u_windowFetch (
		.clock, .resetApp, .reqValid, .reqX, .reqY, .reqMode, .reqReady,
		.memRead, .memAddr, .memData, .winValid, .winReady,
		.winP1, .winP2, .winP3, .winP4, .winP6, .winP7, .winP8, .winP9,
		.winCentre, .winClass, .winMode, .winX, .winY
	);

	sobelKernel #(.screenWidth(screenWidth), .screenHeight(screenHeight)) u_sobelKernel (
		.clock, .resetApp, .winValid, .winReady,
		.winP1, .winP2, .winP3, .winP4, .winP6, .winP7, .winP8, .winP9,
		.winCentre, .winClass, .winMode, .winX, .winY, .thresholdValue,
		.grayValid, .grayReady, .grayValue, .grayX, .grayY
	);

	pixelFormatter #(.screenWidth(screenWidth), .screenHeight(screenHeight)) u_pixelFormatter (
		.clock, .resetApp, .grayValid, .grayReady, .grayValue, .grayX, .grayY,
		.pixelValid, .pixelReady, .pixelX, .pixelY, .pixelData
	);

endmodule

//--- tbSobelModel.svh
/*
 * reference model of the edge viewer
 * image copy, threshold lookup, expected gray value and rgb565 per position
 */

`ifndef tbSobelModelSvh
`define tbSobelModelSvh

grayT modelImage [0:imageWidth*imageHeight-1]; // row-major, same as the DUT store

// default first, then one level per select bit
localparam int levelTable [0:7] = '{50, 100, 120, 140, 160, 180, 200, 220};

function automatic int pixelAt(input int x, input int y);
	return int'(modelImage[y * imageWidth + x]);
endfunction

function automatic int clamp255(input int value);
	return (value > 255) ? 255 : value;
endfunction

// several or no bits set fall back to the default
function automatic grayT thresholdFor(input logic [thresholdCount-1:0] select);
	int level;
	level = levelTable[0];
	if ($countones(select) == 1) begin
		for (int i = 0; i < thresholdCount; i++)
			if (select[i]) level = levelTable[i + 1];
	end
	return grayT'(level);
endfunction

function automatic grayT expectedGray(input int x, input int y, input viewModeT mode,
		input grayT threshold);
	int top;
	int bottom;
	int left;
	int right;
	int gradX;
	int gradY;
	int magnitude;
	if (x >= imageWidth || y >= imageHeight) return 8'd0; // off the image, black
	if (mode == viewGray) return grayT'(pixelAt(x, y));
	if (x == 0 || y == 0 || x == imageWidth - 1 || y == imageHeight - 1)
		return 8'hFF; // border is white in both edge views
	top    = clamp255(pixelAt(x - 1, y - 1) + 2 * pixelAt(x, y - 1) + pixelAt(x + 1, y - 1));
	bottom = clamp255(pixelAt(x - 1, y + 1) + 2 * pixelAt(x, y + 1) + pixelAt(x + 1, y + 1));
	left   = clamp255(pixelAt(x - 1, y - 1) + 2 * pixelAt(x - 1, y) + pixelAt(x - 1, y + 1));
	right  = clamp255(pixelAt(x + 1, y - 1) + 2 * pixelAt(x + 1, y) + pixelAt(x + 1, y + 1));
	gradY  = (top > bottom) ? top - bottom : 0; // negative gradients drop to zero
	gradX  = (right > left) ? right - left : 0;
	magnitude = clamp255(gradX + gradY);
	if (mode == viewThreshold && magnitude < int'(threshold)) magnitude = 0;
	return grayT'(magnitude);
endfunction

// red and blue keep 5 bits, green keeps 6
function automatic rgbT packRgb(input grayT gray);
	int red;
	int green;
	red   = int'(gray) >> 3;
	green = int'(gray) >> 2;
	return rgbT'((red << 11) | (green << 5) | red);
endfunction

function automatic rgbT expectedPixel(input int x, input int y, input viewModeT mode,
		input grayT threshold);
	return packRgb(expectedGray(x, y, mode, threshold));
endfunction

`endif

//--- tbSobelEdge.sv
/*
 * testbench of the sobel edge viewer
 * clock, reset, image load, one frame per view and threshold case,
 * random back-pressure frame, stream assertions and watchdog
 */

`timescale 1ns/1ps

module tbSobelEdge import sobelPkg::*; ();

	localparam int imageWidth   = 16;
	localparam int imageHeight  = 12;
	localparam int screenWidth  = 20;
	localparam int screenHeight = 14;
	localparam int addrWidth    = $clog2(imageWidth * imageHeight);
	localparam int xWidth       = $clog2(screenWidth);
	localparam int yWidth       = $clog2(screenHeight);
	localparam int clockPeriod  = 8;
	localparam int frameSize    = screenWidth * screenHeight;
	localparam int frameCount   = 11; // gray, edge, 8 thresholds, back-pressure
	localparam int watchdogCycles = (frameCount + 2) * frameSize * 12;

	logic                      clock;
	logic                      resetApp;
	logic                      loadValid;
	logic [addrWidth-1:0]      loadAddr;
	grayT                      loadData;
	viewModeT                  viewMode;
	logic [thresholdCount-1:0] thresholdSelect;
	logic                      pixelValid;
	logic                      pixelReady;
	logic [xWidth-1:0]         pixelX;
	logic [yWidth-1:0]         pixelY;
	rgbT                       pixelData;

	viewModeT          expectedMode;      // mode of the frame in flight
	grayT              expectedThreshold;
	rgbT               expectedData;
	logic [xWidth-1:0] expX;              // next raster position
	logic [yWidth-1:0] expY;
	int errorCount     = 0;
	int totalTransfers = 0;
	int stallCycles    = 0;
	int resetCycles    = 0;
	int testCount      = 0;

	`include "tbSobelModel.svh"

	sobelEdgeTop #(
		.imageWidth(imageWidth), .imageHeight(imageHeight),
		.screenWidth(screenWidth), .screenHeight(screenHeight)
	) u_sobelEdgeTop (
		.clock, .resetApp, .loadValid, .loadAddr, .loadData, .viewMode, .thresholdSelect,
		.pixelValid, .pixelReady, .pixelX, .pixelY, .pixelData
	);

	initial begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	always_comb expectedData = expectedPixel(int'(expX), int'(expY), expectedMode,
		expectedThreshold);

	// raster position tracker and stream counters
	always @(posedge clock) begin
		if (resetApp) begin
			expX        <= '0;
			expY        <= '0;
			resetCycles <= resetCycles + 1;
		end else begin
			if (pixelValid && !pixelReady) stallCycles <= stallCycles + 1;
			if (pixelValid && pixelReady) begin
				totalTransfers <= totalTransfers + 1;
				if (expX == xWidth'(screenWidth - 1)) begin
					expX <= '0;
					expY <= (expY == yWidth'(screenHeight - 1)) ? '0 : expY + 1'b1; // frame wrap
				end else begin
					expX <= expX + 1'b1;
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// output stream checks
	resetQuiet: assert property (@(posedge clock) (resetApp || $fell(resetApp)) |-> !pixelValid)
	else begin
		errorCount++;
		$display("[ERROR] pixelValid = %h while reset is active", $sampled(pixelValid));
	end

	rasterOrder: assert property (@(posedge clock) disable iff (resetApp)
		(pixelValid && pixelReady) |-> (pixelX == expX && pixelY == expY))
	else begin
		errorCount++;
		$display("[ERROR] pixelX/pixelY = %h/%h, expected %h/%h", $sampled(pixelX),
			$sampled(pixelY), $sampled(expX), $sampled(expY));
	end

	pixelValue: assert property (@(posedge clock) disable iff (resetApp)
		(pixelValid && pixelReady) |-> (pixelData == expectedData))
	else begin
		errorCount++;
		$display("[ERROR] pixelData = %h, expected %h at x %h y %h", $sampled(pixelData),
			$sampled(expectedData), $sampled(expX), $sampled(expY));
	end

	// a stalled pixel keeps valid, data and position
	holdStable: assert property (@(posedge clock) disable iff (resetApp)
		(pixelValid && !pixelReady) |=>
		(pixelValid && $stable(pixelData) && $stable(pixelX) && $stable(pixelY)))
	else begin
		errorCount++;
		$display("[ERROR] stalled pixel changed: pixelValid %h pixelData %h pixelX %h pixelY %h",
			$sampled(pixelValid), $sampled(pixelData), $sampled(pixelX), $sampled(pixelY));
	end

	// ------------------------------------------------------------------------
	// stimulus
	task automatic loadImage;
		int value;
		for (int y = 0; y < imageHeight; y++) begin
			for (int x = 0; x < imageWidth; x++) begin
				value = x * 12 + int'($urandom_range(0, 40)); // ramp plus noise to spread magnitudes
				modelImage[y * imageWidth + x] = grayT'(value);
				@(posedge clock);
				loadValid <= 1'b1;
				loadAddr  <= addrWidth'(y * imageWidth + x);
				loadData  <= grayT'(value);
			end
		end
		@(posedge clock);
		loadValid <= 1'b0;
	endtask

	// reset pulse restarts the scan, so the new mode holds from (0,0)
	task automatic runFrame(input string name, input viewModeT mode,
			input logic [thresholdCount-1:0] select, input bit randomReady);
		int startErrors;
		int startTransfers;
		int startStalls;
		startErrors = errorCount;
		@(posedge clock);
		viewMode          <= mode;
		thresholdSelect   <= select;
		expectedMode      <= mode;
		expectedThreshold <= thresholdFor(select);
		pixelReady        <= 1'b1;
		resetApp          <= 1'b1;
		repeat (2) @(posedge clock);
		resetApp <= 1'b0;
		startTransfers = totalTransfers;
		startStalls    = stallCycles;
		while (totalTransfers - startTransfers < frameSize) begin
			@(posedge clock);
			if (randomReady) pixelReady <= 1'($urandom_range(0, 1));
		end
		pixelReady <= 1'b1; // drain any held pixel before the next reset
		@(posedge clock);
		if (randomReady && stallCycles == startStalls) begin
			errorCount++;
			$display("back-pressure frame never held a pixel, the stall path was not reached");
		end
		testCount++;
		$display("test %-26s pixels %0d errors %0d", name, totalTransfers - startTransfers,
			errorCount - startErrors);
	endtask

	initial begin
		logic [thresholdCount-1:0] select;
		resetApp          <= 1'b1;
		loadValid         <= 1'b0;
		loadAddr          <= '0;
		loadData          <= '0;
		viewMode          <= viewGray;
		thresholdSelect   <= '0;
		pixelReady        <= 1'b1;
		expectedMode      <= viewGray;
		expectedThreshold <= 8'd50;
		void'($urandom(57));
		repeat (2) @(posedge clock);
		loadImage(); // DUT held in reset while the memory loads
		testCount++;
		$display("test %-26s cycles %0d errors %0d", "reset", resetCycles, errorCount);
		runFrame("gray view", viewGray, '0, 1'b0);
		runFrame("edge view", viewEdge, '0, 1'b0);
		for (int i = 0; i < 8; i++) begin
			// case 0 has two bits set and takes the default level
			select = (i == 0) ? 7'b0100010 : 7'(1 << (i - 1));
			runFrame($sformatf("threshold select %07b", select), viewThreshold, select, 1'b0);
		end
		runFrame("back-pressure", viewEdge, '0, 1'b1);
		$display("tests %0d, pixels checked %0d, errors %0d", testCount, totalTransfers,
			errorCount);
		if (errorCount == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// about 12 cycles per screen position for every frame
	initial begin
		#(watchdogCycles * clockPeriod);
		$display("watchdog expired after %0d cycles, the pixel stream did not finish",
			watchdogCycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- sobelEdge.f
+incdir+.
sobelPkg.sv
frameScanner.sv
imageMemory.sv
windowFetch.sv
sobelKernel.sv
pixelFormatter.sv
sobelEdgeTop.sv
tbSobelEdge.sv

//--- runSim.sh
#!/usr/bin/env bash
# build the sobel edge viewer testbench with verilator and run it
# the run passes only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sobelEdge.f --top-module tbSobelEdge -o simSobelEdge \
	&& ./obj_dir/simSobelEdge | tee /dev/stderr | grep -x "TEST OK" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
